// File: logic/eth_rx_macros.svh
`ifndef ETH_RX_MACROS_SVH
`define ETH_RX_MACROS_SVH

// Receive buffer geometry, byte addressed
`define ETH_BUF_ADDR_W 11
`define ETH_BUF_BYTES 2048

// Line nibbles, low nibble of each octet first
`define ETH_PREAMBLE_NIB 4'h5
`define ETH_SFD_NIB 4'hD          // Upper half of the 0xD5 delimiter

// CRC-32 preset and the value a good frame leaves behind
`define ETH_CRC_INIT 32'hFFFF_FFFF
`define ETH_CRC_RESIDUE 32'hC704_DD7B

`endif

// File: logic/eth_mii_pkg.sv
package eth_mii_pkg;

   // Receiver FSM
   typedef enum logic [2:0] {
      IDLE,
      PREAMBLE,
      DATA_LO,    // Expecting low nibble of a byte
      DATA_HI,    // Expecting high nibble of a byte
      HOLD        // Wait for data-valid to drop
   } eth_rx_state_e;

   typedef logic [3:0] eth_nibble_t;   // MII receive data
   typedef logic [7:0] eth_byte_t;
   typedef logic [31:0] eth_crc_t;

endpackage

// File: logic/eth_bus_pkg.sv
package eth_bus_pkg;

   // Register select, taken from the word address
   typedef enum logic [1:0] {
      REG_STATUS = 2'd0,
      REG_SIZE   = 2'd1,
      REG_CTRL   = 2'd2,
      REG_BUF    = 2'd3   // Upper half of the window
   } eth_reg_e;

   typedef logic [31:0] eth_word_t;
   typedef logic [11:0] eth_size_t;    // Wide enough for a full 2048

   // Status register layout, rcvd in bit 0
   typedef struct packed {
      logic [27:0] pad;
      logic        dv_seen;
      logic        oversize;
      logic        crc_err;
      logic        rcvd;
   } eth_rx_status_t;

endpackage

// File: logic/eth_rx_buf_if.sv
`timescale 1ns/10ps
`include "eth_rx_macros.svh"

// Byte writes from the receiver into the frame buffer
interface eth_rx_buf_if import eth_mii_pkg::*; ();

   logic                       wr;      // One byte per cycle, no stall
   logic [`ETH_BUF_ADDR_W-1:0] addr;
   eth_byte_t                  data;
   logic                       clear;   // Pulses at start of frame

   modport rx (output wr, addr, data, clear);
   modport mem (input wr, addr, data, clear);

endinterface

// File: logic/eth_rx_stat_if.sv
`timescale 1ns/10ps

// Frame status towards the registers, commands back to the receiver
interface eth_rx_stat_if import eth_bus_pkg::*; ();

   logic      rcvd;
   logic      crc_err;
   logic      oversize;
   logic      dv_seen;
   eth_size_t size;       // Whole bytes, saturates at buffer size

   // Single-cycle pulses from the host side
   logic      rcv_ack;
   logic      soft_rst;

   modport rx (
      output rcvd, crc_err, oversize, dv_seen, size,
      input  rcv_ack, soft_rst
   );

   modport regs (
      input  rcvd, crc_err, oversize, dv_seen, size,
      output rcv_ack, soft_rst
   );

endinterface

// File: logic/eth_crc32.sv
`timescale 1ns/10ps
`include "eth_rx_macros.svh"

// Ethernet CRC-32, one byte per enabled cycle
// Bits enter LSB first; the register is kept MSB first, so a good frame
// leaves the C704DD7B residue
module eth_crc32 import eth_mii_pkg::*; (
   input  logic      MRxClk,
   input  logic      ETH_PHY_RESETN,
   input  logic      clear_i,
   input  logic      en_i,
   input  eth_byte_t data_i,
   output eth_crc_t  crc_o
);

   localparam eth_crc_t POLY = 32'h04C1_1DB7;

   eth_crc_t crc_q;
   eth_crc_t crc_d;

   always_comb begin
      crc_d = crc_q;
      for (int i = 0; i < 8; i++) begin
         crc_d = {crc_d[30:0], 1'b0} ^ ((crc_d[31] ^ data_i[i]) ? POLY : '0);
      end
   end

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN)
         crc_q <= `ETH_CRC_INIT;
      else if (clear_i)
         crc_q <= `ETH_CRC_INIT;   // Preset wins over a byte
      else if (en_i)
         crc_q <= crc_d;
   end

   assign crc_o = crc_q;

endmodule

// File: logic/eth_mii_rx.sv
`timescale 1ns/10ps
`include "eth_rx_macros.svh"

// MII receive path: preamble/SFD hunt, nibble pairing, byte count and status
module eth_mii_rx import eth_mii_pkg::*, eth_bus_pkg::*; (
   input  logic        MRxClk,
   input  logic        ETH_PHY_RESETN,
   input  eth_nibble_t mii_rxd_i,
   input  logic        mii_rxdv_i,
   eth_rx_buf_if.rx    buf_o,
   eth_rx_stat_if.rx   stat
);

   localparam eth_size_t BUF_BYTES = eth_size_t'(`ETH_BUF_BYTES);

   eth_rx_state_e state_q;
   eth_rx_state_e state_d;
   eth_nibble_t   lo_q;        // Low nibble waiting for its partner
   eth_size_t     cnt_q;       // Bytes in the current frame
   logic          ovf_q;       // Frame ran past the buffer
   eth_crc_t      crc;
   logic          sfd_hit;
   logic          byte_in;
   logic          frame_end;
   eth_byte_t     byte_d;

   assign sfd_hit   = (state_q == PREAMBLE) && mii_rxdv_i && (mii_rxd_i == `ETH_SFD_NIB);
   assign byte_in   = (state_q == DATA_HI) && mii_rxdv_i;
   assign frame_end = ((state_q == DATA_LO) || (state_q == DATA_HI)) && !mii_rxdv_i;
   assign byte_d    = {mii_rxd_i, lo_q};

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            // A new frame is refused while the last one is unread
            if (mii_rxdv_i) begin
               if (stat.rcvd || (mii_rxd_i != `ETH_PREAMBLE_NIB))
                  state_d = HOLD;
               else
                  state_d = PREAMBLE;
            end
         end
         PREAMBLE: begin
            if (!mii_rxdv_i)
               state_d = IDLE;
            else if (sfd_hit)
               state_d = DATA_LO;
            else if (mii_rxd_i != `ETH_PREAMBLE_NIB)
               state_d = HOLD;     // Noise, drop the rest
         end
         DATA_LO: state_d = mii_rxdv_i ? DATA_HI : IDLE;
         DATA_HI: state_d = mii_rxdv_i ? DATA_LO : IDLE;   // Odd nibble dropped
         default: begin
            if (!mii_rxdv_i)
               state_d = IDLE;
         end
      endcase
   end

   // FSM, write strobe and byte counter
   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state_q     <= IDLE;
         cnt_q       <= '0;
         ovf_q       <= 1'b0;
         buf_o.wr    <= 1'b0;
         buf_o.clear <= 1'b0;
      end else begin
         state_q     <= stat.soft_rst ? HOLD : state_d;
         buf_o.clear <= sfd_hit;
         buf_o.wr    <= byte_in && (cnt_q < BUF_BYTES);
         if (sfd_hit) begin
            cnt_q <= '0;
            ovf_q <= 1'b0;
         end else if (byte_in) begin
            if (cnt_q == BUF_BYTES)
               ovf_q <= 1'b1;      // Count saturates, CRC keeps running
            else
               cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge MRxClk) begin
      if (state_q == DATA_LO)
         lo_q <= mii_rxd_i;
      if (byte_in) begin
         buf_o.data <= byte_d;
         buf_o.addr <= cnt_q[`ETH_BUF_ADDR_W-1:0];
      end
   end

   // Frame status, latched when data-valid drops
   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         stat.rcvd     <= 1'b0;
         stat.crc_err  <= 1'b0;
         stat.oversize <= 1'b0;
         stat.dv_seen  <= 1'b0;
         stat.size     <= '0;
      end else if (stat.soft_rst) begin
         stat.rcvd     <= 1'b0;
         stat.crc_err  <= 1'b0;
         stat.oversize <= 1'b0;
         stat.dv_seen  <= 1'b0;
         stat.size     <= '0;
      end else begin
         if (mii_rxdv_i)
            stat.dv_seen <= 1'b1;
         if (stat.rcv_ack) begin
            stat.rcvd     <= 1'b0;
            stat.crc_err  <= 1'b0;
            stat.oversize <= 1'b0;
         end
         if (frame_end) begin
            stat.rcvd     <= 1'b1;
            stat.crc_err  <= (crc != `ETH_CRC_RESIDUE);
            stat.oversize <= ovf_q;
            stat.size     <= cnt_q;
         end
      end
   end

   // Fed straight from the pins so the residue is ready at frame end
   eth_crc32 u_crc (
      .MRxClk         (MRxClk),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .clear_i        (buf_o.clear),
      .en_i           (byte_in),
      .data_i         (byte_d),
      .crc_o          (crc)
   );

endmodule

// File: logic/eth_rx_buffer.sv
`timescale 1ns/10ps
`include "eth_rx_macros.svh"

// Receive frame buffer, byte writes in, 32-bit host reads out
module eth_rx_buffer import eth_bus_pkg::*; (
   input  logic                       MRxClk,
   eth_rx_buf_if.mem                  buf_i,
   input  logic                       rd_en_i,
   input  logic [`ETH_BUF_ADDR_W-3:0] rd_addr_i,
   output eth_word_t                  rd_data_o
);

   localparam int WORDS = `ETH_BUF_BYTES / 4;

   eth_word_t                  mem [WORDS];
   eth_word_t                  wr_word;
   logic [3:0]                 wr_be;
   logic [1:0]                 lane;
   logic [`ETH_BUF_ADDR_W-3:0] wr_waddr;

   // Little endian lanes, byte 0 of the frame in bits 7:0
   assign lane     = buf_i.addr[1:0];
   assign wr_waddr = buf_i.addr[`ETH_BUF_ADDR_W-1:2];
   assign wr_word  = eth_word_t'(buf_i.data) << {lane, 3'b000};
   assign wr_be    = 4'b0001 << lane;

   // Contents are left alone on a new frame
   always_ff @(posedge MRxClk) begin
      if (buf_i.wr) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_be[b])
               mem[wr_waddr][b*8 +: 8] <= wr_word[b*8 +: 8];
         end
      end
   end

   // Host port
   always_ff @(posedge MRxClk) begin
      if (rd_en_i)
         rd_data_o <= mem[rd_addr_i];   // Valid on the next cycle
   end

endmodule

// File: logic/eth_rx_regs.sv
`timescale 1ns/10ps
`include "eth_rx_macros.svh"

// Wishbone classic slave for the receive status and buffer
module eth_rx_regs import eth_bus_pkg::*; (
   input  logic                       MRxClk,
   input  logic                       ETH_PHY_RESETN,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  logic [11:0]                wb_adr_i,
   input  eth_word_t                  wb_dat_i,
   output eth_word_t                  wb_dat_o,
   output logic                       wb_ack_o,
   eth_rx_stat_if.regs                stat,
   output logic                       rd_en_o,
   output logic [`ETH_BUF_ADDR_W-3:0] rd_addr_o,
   input  eth_word_t                  rd_data_i,
   output logic                       irq_o
);

   eth_reg_e       sel;
   eth_reg_e       sel_q;       // Select held for the ack cycle
   eth_rx_status_t status;
   logic           req;
   logic           ctrl_wr;

   // New request only when not already acking, so held stb gives 2-cycle beats
   assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

   always_comb begin
      if (wb_adr_i[11])
         sel = REG_BUF;
      else if (wb_adr_i[10:2] == 9'd0)
         sel = REG_STATUS;
      else if (wb_adr_i[10:2] == 9'd1)
         sel = REG_SIZE;
      else
         sel = REG_CTRL;           // Other low words read as zero
   end

   assign ctrl_wr = req && wb_we_i && (wb_adr_i[11:2] == 10'd2);

   // Buffer read launched with the request, data lands with ack
   assign rd_en_o   = req && !wb_we_i && (sel == REG_BUF);
   assign rd_addr_o = wb_adr_i[`ETH_BUF_ADDR_W-1:2];

   always_comb begin
      status          = '0;
      status.rcvd     = stat.rcvd;
      status.crc_err  = stat.crc_err;
      status.oversize = stat.oversize;
      status.dv_seen  = stat.dv_seen;
      case (sel_q)
         REG_STATUS: wb_dat_o = status;
         REG_SIZE:   wb_dat_o = eth_word_t'(stat.size);
         REG_CTRL:   wb_dat_o = '0;
         default:    wb_dat_o = rd_data_i;
      endcase
   end

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         wb_ack_o      <= 1'b0;
         sel_q         <= REG_STATUS;
         stat.rcv_ack  <= 1'b0;
         stat.soft_rst <= 1'b0;
      end else begin
         wb_ack_o      <= req;
         stat.rcv_ack  <= ctrl_wr && wb_dat_i[0];   // Self-clearing pulses
         stat.soft_rst <= ctrl_wr && wb_dat_i[1];
         if (req)
            sel_q <= sel;
      end
   end

   assign irq_o = stat.rcvd;   // Level, drops on ack

endmodule

// File: logic/eth_rx_core.sv
`timescale 1ns/10ps
`include "eth_rx_macros.svh"

// Ethernet receive core top
module eth_rx_core import eth_mii_pkg::*, eth_bus_pkg::*; (
   input  logic        MRxClk,
   input  logic        ETH_PHY_RESETN,
   input  eth_nibble_t mii_rxd_i,
   input  logic        mii_rxdv_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [11:0] wb_adr_i,
   input  eth_word_t   wb_dat_i,
   output eth_word_t   wb_dat_o,
   output logic        wb_ack_o,
   output logic        irq_o
);

   logic                       rd_en;
   logic [`ETH_BUF_ADDR_W-3:0] rd_addr;
   eth_word_t                  rd_data;

   eth_rx_buf_if  buf_if ();
   eth_rx_stat_if stat_if ();

   eth_mii_rx u_rx (
      .MRxClk         (MRxClk),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .mii_rxd_i      (mii_rxd_i),
      .mii_rxdv_i     (mii_rxdv_i),
      .buf_o          (buf_if.rx),
      .stat           (stat_if.rx)
   );

   eth_rx_buffer u_buf (
      .MRxClk    (MRxClk),
      .buf_i     (buf_if.mem),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   eth_rx_regs u_regs (
      .MRxClk         (MRxClk),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .wb_cyc_i       (wb_cyc_i),
      .wb_stb_i       (wb_stb_i),
      .wb_we_i        (wb_we_i),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_o       (wb_ack_o),
      .stat           (stat_if.regs),
      .rd_en_o        (rd_en),
      .rd_addr_o      (rd_addr),
      .rd_data_i      (rd_data),
      .irq_o          (irq_o)
   );

endmodule

// File: test/eth_rx_tb.sv
`timescale 1ns/10ps
`include "eth_rx_macros.svh"

module eth_rx_tb import eth_mii_pkg::*, eth_bus_pkg::*; ();

   localparam int BUF_WORDS = `ETH_BUF_BYTES / 4;
   localparam int WAIT_LIMIT = 200;
   localparam eth_crc_t RESIDUE_REFL = 32'hDEBB_20E3;   // Line residue, bit reversed

   logic        MRxClk;
   logic        ETH_PHY_RESETN;
   eth_nibble_t mii_rxd_i;
   logic        mii_rxdv_i;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [11:0] wb_adr_i;
   eth_word_t   wb_dat_i;
   eth_word_t   wb_dat_o;
   logic        wb_ack_o;
   logic        irq_o;

   integer         seed = 10;
   int             errors = 0;
   int             timeouts = 0;
   eth_byte_t      tx_frame[$];
   eth_word_t      exp_words[BUF_WORDS];   // Model of the buffer, stale bytes included
   eth_size_t      exp_size;
   eth_rx_status_t exp_status;

   eth_rx_core dut_i (.*);

   initial MRxClk = 1'b0;
   always #4 MRxClk = ~MRxClk;

   task automatic check_status(input string name, input eth_rx_status_t got,
                               input eth_rx_status_t exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %s got 0x%08h exp 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_size(input string name, input eth_size_t got, input eth_size_t exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %s got 0x%03h exp 0x%03h", name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input eth_word_t got, input eth_word_t exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %s got 0x%08h exp 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
      end
   endtask

   // Reflected CRC-32, LSB first
   function automatic eth_crc_t crc_calc(input eth_byte_t data[$]);
      eth_crc_t c;
      c = 32'hFFFF_FFFF;
      foreach (data[i]) begin
         c ^= {24'h0, data[i]};
         for (int b = 0; b < 8; b++)
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
      return c;
   endfunction

   // Random payload plus FCS, optionally damaged afterwards
   function automatic void make_frame(input int len, input bit corrupt);
      eth_crc_t fcs;
      tx_frame.delete();
      for (int i = 0; i < len; i++)
         tx_frame.push_back(eth_byte_t'($random(seed)));
      fcs = ~crc_calc(tx_frame);
      for (int i = 0; i < 4; i++)
         tx_frame.push_back(fcs[i*8 +: 8]);   // FCS goes out low byte first
      if (corrupt)
         tx_frame[len/2] ^= 8'h5A;
   endfunction

   // Expected flags, size and buffer words for an accepted frame
   function automatic void expect_frame(input eth_byte_t frame[$]);
      int n;
      n = frame.size();
      for (int i = 0; i < n && i < `ETH_BUF_BYTES; i++)
         exp_words[i/4][(i%4)*8 +: 8] = frame[i];
      exp_size            = (n > `ETH_BUF_BYTES) ? eth_size_t'(`ETH_BUF_BYTES) : eth_size_t'(n);
      exp_status          = '0;
      exp_status.rcvd     = 1'b1;
      exp_status.dv_seen  = 1'b1;
      exp_status.oversize = (n > `ETH_BUF_BYTES);
      exp_status.crc_err  = (crc_calc(frame) != RESIDUE_REFL);
   endfunction

   task automatic drive_nibble(input eth_nibble_t nib);
      mii_rxdv_i = 1'b1;
      mii_rxd_i  = nib;
      @(negedge MRxClk);
   endtask

   task automatic send_frame();
      for (int i = 0; i < 15; i++)
         drive_nibble(`ETH_PREAMBLE_NIB);
      drive_nibble(`ETH_SFD_NIB);
      foreach (tx_frame[i]) begin
         drive_nibble(tx_frame[i][3:0]);
         drive_nibble(tx_frame[i][7:4]);
      end
      mii_rxdv_i = 1'b0;
      mii_rxd_i  = '0;
      @(negedge MRxClk);
   endtask

   task automatic wait_irq(input string tag);
      int n;
      n = 0;
      while (!irq_o && n < WAIT_LIMIT) begin
         @(negedge MRxClk);
         n++;
      end
      if (!irq_o) begin
         timeouts++;
         $display("Timeout: the %s frame never raised irq_o", tag);
      end
   endtask

   task automatic bus_write(input logic [11:0] addr, input eth_word_t data);
      int n;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b1;
      wb_adr_i = addr;
      wb_dat_i = data;
      n = 0;
      do begin
         @(negedge MRxClk);
         n++;
      end while (!wb_ack_o && n < WAIT_LIMIT);
      if (!wb_ack_o) begin
         timeouts++;
         $display("Timeout: no ack for the bus write to 0x%03h", addr);
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_read(input logic [11:0] addr, output eth_word_t data);
      int n;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b0;
      wb_adr_i = addr;
      n = 0;
      do begin
         @(negedge MRxClk);
         n++;
      end while (!wb_ack_o && n < WAIT_LIMIT);
      data = wb_dat_o;   // Valid with ack
      if (!wb_ack_o) begin
         timeouts++;
         $display("Timeout: no ack for the bus read from 0x%03h", addr);
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   task automatic check_status_reg(input string tag);
      eth_word_t d;
      bus_read(12'h000, d);
      check_status({tag, " status"}, eth_rx_status_t'(d), exp_status);
   endtask

   // Status, size and every buffer word the frame covers
   task automatic check_frame(input string tag);
      eth_word_t d;
      int        nwords;
      check_status_reg(tag);
      bus_read(12'h004, d);
      check_size({tag, " size"}, d[11:0], exp_size);
      nwords = (int'(exp_size) + 3) / 4;
      for (int w = 0; w < nwords; w++) begin
         bus_read(12'h800 + 12'(w * 4), d);
         check_word($sformatf("%s buf[%0d]", tag, w), d, exp_words[w]);
      end
   endtask

   task automatic ack_frame(input string tag);
      bus_write(12'h008, 32'h1);
      exp_status.rcvd     = 1'b0;
      exp_status.crc_err  = 1'b0;
      exp_status.oversize = 1'b0;
      check_status_reg(tag);
      check_bit({tag, " irq_o"}, irq_o, 1'b0);
   endtask

   initial begin
      mii_rxd_i      = '0;
      mii_rxdv_i     = 1'b0;
      wb_cyc_i       = 1'b0;
      wb_stb_i       = 1'b0;
      wb_we_i        = 1'b0;
      wb_adr_i       = '0;
      wb_dat_i       = '0;
      ETH_PHY_RESETN = 1'b0;
      repeat (3) @(posedge MRxClk);
      @(negedge MRxClk);
      ETH_PHY_RESETN = 1'b1;
      @(negedge MRxClk);

      exp_status = '0;
      exp_size   = '0;
      check_bit("reset irq_o", irq_o, 1'b0);
      check_frame("reset");

      make_frame(64, 1'b0);
      expect_frame(tx_frame);
      send_frame();
      wait_irq("good");
      check_bit("good irq_o", irq_o, 1'b1);
      check_frame("good");

      // Refused while rcvd is still set
      make_frame(64, 1'b0);
      send_frame();
      repeat (8) @(negedge MRxClk);
      check_frame("held");
      ack_frame("held ack");

      make_frame(32, 1'b0);
      expect_frame(tx_frame);
      send_frame();
      wait_irq("third");
      check_frame("third");
      ack_frame("third ack");

      make_frame(64, 1'b1);
      expect_frame(tx_frame);
      send_frame();
      wait_irq("corrupt");
      check_frame("corrupt");
      ack_frame("corrupt ack");

      make_frame(2096, 1'b0);
      expect_frame(tx_frame);
      send_frame();
      wait_irq("oversize");
      check_frame("oversize");
      ack_frame("oversize ack");

      // Data-valid noise without an SFD
      drive_nibble(4'h3);
      for (int i = 0; i < 20; i++)
         drive_nibble(eth_nibble_t'($random(seed)));
      mii_rxdv_i = 1'b0;
      repeat (8) @(negedge MRxClk);
      check_bit("noise irq_o", irq_o, 1'b0);
      check_status_reg("noise");

      // Every flag set before the soft reset
      make_frame(2096, 1'b1);
      expect_frame(tx_frame);
      send_frame();
      wait_irq("flagged");
      check_status_reg("flagged");

      bus_write(12'h008, 32'h2);
      exp_status = '0;
      exp_size   = '0;
      check_frame("soft reset");
      check_bit("soft reset irq_o", irq_o, 1'b0);

      $display("errors=%0d timeouts=%0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// File: eth_rx.f
+incdir+logic
logic/eth_mii_pkg.sv
logic/eth_bus_pkg.sv
logic/eth_rx_buf_if.sv
logic/eth_rx_stat_if.sv
logic/eth_crc32.sv
logic/eth_mii_rx.sv
logic/eth_rx_buffer.sv
logic/eth_rx_regs.sv
logic/eth_rx_core.sv
test/eth_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -j 0 -f eth_rx.f --top-module eth_rx_tb -o eth_rx_sim
./obj_dir/eth_rx_sim > sim.log
cat sim.log
if grep -qx "sim passed" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
